// ==== sources.f ====
+incdir+.
cart_pkg.sv
lohi_rom_map.sv
flash_rom_map.sv
msu_regs.sv
map_mux.sv
cart_top.sv
cart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run cart_tb with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing -f sources.f --top-module cart_tb -Mdir "$build" -o cart_tb_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

"./$build/cart_tb_sim" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

if ! grep -q "TEST PASSED" "$log"; then
	echo "no pass line found in $log"
	exit 1
fi

exit 0

// ==== cart_tb.sv ====
`timescale 1ns/100ps
`include "cart_settings.svh"

module cart_tb;
	import cart_pkg::*;

	localparam int n_rand      = 24;
	localparam int num_access  = 4 * n_rand + 60;
	localparam int watchdog_ns = (16 + 3 * num_access) * 4 * 2;   // 3 cycles per access, 2x margin
	localparam logic [47:0] msu_id = "S-MSU1";

	logic        mclk;
	logic        rst_n;
	logic        sysclkf_ce;
	cpu_bus_t    cpu;
	cpu_data_t   cpu_di;
	map_ctrl_t   map_ctrl;
	rom_addr_t   rom_mask;
	bsram_addr_t bsram_mask;
	rom_data_t   rom_q;
	cpu_data_t   bsram_q;
	cart_bus_t   cart;
	logic        map_active;
	logic        msu_enable;
	logic        track_mounting;
	logic        track_missing;
	logic        audio_stop;
	track_t      track_num;
	logic        track_request;
	cpu_data_t   volume;
	logic        audio_playing;
	logic        audio_repeat;
	logic [15:0] lfsr;

	cart_top dut0 (.*);

	initial begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;
	end

	initial begin
		#(watchdog_ns);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired before the tests finished");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // galois, taps 16 14 13 11
		end
		return v;
	endfunction

	function automatic cpu_bus_t make_bus(input cpu_addr_t ca, input logic rd_n, input logic wr_n,
		input logic romsel_n, input logic ramsel_n, input cpu_data_t d);
		cpu_bus_t b;
		b.ca       = ca;
		b.rd_n     = rd_n;
		b.wr_n     = wr_n;
		b.romsel_n = romsel_n;
		b.ramsel_n = ramsel_n;
		b.dout     = d;
		return b;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch, run stopped");
		end
	endtask

	// order rom ce/oe/we then bsram ce/oe/we
	task automatic check_strobes(input logic [5:0] exp);
		check("cart enables", 32'({cart.rom_ce_n, cart.rom_oe_n, cart.rom_we_n,
			cart.bsram_ce_n, cart.bsram_oe_n, cart.bsram_we_n}), 32'(exp));
	endtask

	task automatic next_edge();
		@(posedge mclk);
		#1;
	endtask

	task automatic reg_write(input cpu_addr_t ca, input cpu_data_t d);
		cpu        = make_bus(ca, 1'b1, 1'b0, 1'b1, 1'b1, d);
		sysclkf_ce = 1'b1;
		next_edge();
		sysclkf_ce = 1'b0;
		cpu        = make_bus(24'h0, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00);
	endtask

	task automatic lorom_read(input cpu_addr_t ca);
		rom_addr_t exp_addr;
		cpu_data_t exp_byte;
		exp_addr = {2'b00, ca[22:16], ca[14:0]} & rom_mask;   // a15 dropped
		rom_q    = 16'(rand_bits(16));
		cpu      = make_bus(ca, 1'b0, 1'b1, 1'b0, 1'b1, 8'h00);
		#1;
		exp_byte = exp_addr[0] ? rom_q[15:8] : rom_q[7:0];
		check("cpu_di", 32'(cpu_di), 32'(exp_byte));
		next_edge();
		check("rom_addr", 32'(cart.rom_addr), 32'(exp_addr));
		check_strobes(6'b001111);
	endtask

	task automatic hirom_access(input cpu_addr_t ca, input logic is_ram, input logic is_write,
		input cpu_data_t d);
		rom_addr_t   exp_rom;
		bsram_addr_t exp_ram;
		cpu_data_t   exp_byte;
		exp_rom = {2'b00, ca[21:0]} & rom_mask;
		exp_ram = {2'b00, ca[20:16], ca[12:0]} & bsram_mask;
		rom_q   = 16'(rand_bits(16));
		bsram_q = 8'(rand_bits(8));
		cpu     = make_bus(ca, is_write, !is_write, is_ram, 1'b1, d);
		#1;
		if (!is_write) begin
			exp_byte = is_ram ? bsram_q : (exp_rom[0] ? rom_q[15:8] : rom_q[7:0]);
			check("cpu_di", 32'(cpu_di), 32'(exp_byte));
		end
		next_edge();
		if (is_ram) begin
			check("bsram_addr", 32'(cart.bsram_addr), 32'(exp_ram));
			if (is_write) begin
				check_strobes(6'b111010);
				check("bsram_d", 32'(cart.bsram_d), 32'(d));
			end else begin
				check_strobes(6'b111001);
			end
		end else begin
			check("rom_addr", 32'(cart.rom_addr), 32'(exp_rom));
			check_strobes(6'b001111);
		end
	endtask

	task automatic flash_write(input cpu_addr_t ca, input cpu_data_t d, input logic wen);
		cpu = make_bus(ca, 1'b1, 1'b0, 1'b0, 1'b1, d);
		next_edge();
		check("rom_addr", 32'(cart.rom_addr), 32'({2'b00, ca[21:0]} & rom_mask));
		check_strobes(wen ? 6'b010111 : 6'b011111);
		if (wen) begin
			check("rom_d", 32'(cart.rom_d), 32'(d));
		end
	endtask

	task automatic msu_read(input cpu_addr_t ca, input cpu_data_t exp);
		cpu = make_bus(ca, 1'b0, 1'b1, 1'b1, 1'b1, 8'h00);
		#1;
		check("cpu_di", 32'(cpu_di), 32'(exp));
		next_edge();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_values();
		check_strobes(6'b111111);
		check("track_request", 32'(track_request), 32'd0);
		check("audio_playing", 32'(audio_playing), 32'd0);
		check("audio_repeat", 32'(audio_repeat), 32'd0);
		check("volume", 32'(volume), 32'd0);
		check("track_num", 32'(track_num), 32'd0);
	endtask

	task automatic lorom_reads();
		map_ctrl = {4'h0, `CART_MAP_LOROM};
		rom_mask = 24'h07FFFF;   // 512k rom
		next_edge();
		check("map_active", 32'(map_active), 32'd0);
		for (int i = 0; i < n_rand; i++) begin
			lorom_read(24'(rand_bits(24)) | 24'h008000);
		end
		lorom_read(24'hC08001);
		check("rom_addr", 32'(cart.rom_addr), 32'h000001);   // bank c0 folds to 0
	endtask

	task automatic hirom_bsram();
		cpu_addr_t ca;
		map_ctrl   = {4'h0, `CART_MAP_HIROM};
		rom_mask   = 24'h3FFFFF;
		bsram_mask = 20'h07FFF;
		for (int i = 0; i < n_rand; i++) begin
			ca        = 24'(rand_bits(24));
			ca[23:22] = 2'b11;
			hirom_access(ca, 1'b0, 1'b0, 8'h00);
			ca        = 24'(rand_bits(24));
			ca[22:21] = 2'b01;   // banks 20-3f, a0-bf
			ca[15:13] = 3'b011;  // 6000-7fff
			hirom_access(ca, 1'b1, 1'(rand_bits(1)), 8'(rand_bits(8)));
		end
	endtask

	task automatic flash_writes();
		cpu_addr_t wr_ca [4];
		cpu_data_t wr_d [4];
		map_ctrl = {4'h0, `CART_MAP_FLASH};
		rom_mask = 24'h3FFFFF;
		next_edge();
		check("map_active", 32'(map_active), 32'd1);
		for (int i = 0; i < 4; i++) begin
			wr_ca[i] = 24'(rand_bits(24)) | 24'hC00000;
			wr_d[i]  = 8'(rand_bits(8));
			flash_write(wr_ca[i], wr_d[i], 1'b0);
		end
		reg_write({8'h00, `CART_FLASH_WEN_ADDR}, 8'h01);
		for (int i = 0; i < 4; i++) begin
			flash_write(wr_ca[i], wr_d[i], 1'b1);
		end
		hirom_access(wr_ca[0], 1'b0, 1'b0, 8'h00);
		reg_write({8'h00, `CART_FLASH_WEN_ADDR}, 8'h00);
		flash_write(wr_ca[1], wr_d[1], 1'b0);
	endtask

	task automatic audio_regs();
		cpu_data_t lo;
		cpu_data_t hi;
		cpu_data_t vol;
		map_ctrl   = {4'h0, `CART_MAP_LOROM};
		rom_mask   = 24'h3FFFFF;
		msu_enable = 1'b1;
		for (int i = 0; i < 6; i++) begin
			msu_read(24'h002002 + 24'(i), msu_id[47 - 8 * i -: 8]);
		end
		for (int k = 0; k < 4; k++) begin
			track_mounting = k[1];
			track_missing  = k[0];
			msu_read(24'h802000, {1'b0, track_mounting, 2'b00, track_missing, 3'd1});
		end
		lo = 8'(rand_bits(8));
		hi = 8'(rand_bits(8));
		reg_write(24'h002004, lo);
		check("track_request", 32'(track_request), 32'd0);
		reg_write(24'h802005, hi);
		check("track_request", 32'(track_request), 32'd1);
		check("track_num", 32'(track_num), 32'({hi, lo}));
		next_edge();
		check("track_request", 32'(track_request), 32'd0);
		vol = 8'(rand_bits(8));
		reg_write(24'h002006, vol);
		check("volume", 32'(volume), 32'(vol));
		reg_write(24'h002007, 8'h03);
		check("audio_playing", 32'(audio_playing), 32'd1);
		check("audio_repeat", 32'(audio_repeat), 32'd1);
		track_mounting = 1'b1;
		track_missing  = 1'b0;
		msu_read(24'h002000, {1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 3'd1});
		audio_stop = 1'b1;
		next_edge();
		audio_stop = 1'b0;
		check("audio_playing", 32'(audio_playing), 32'd0);
		check("audio_repeat", 32'(audio_repeat), 32'd1);
		rom_q      = 16'h5AA5;
		msu_enable = 1'b0;
		msu_read(24'h002002, 8'hA5);   // even rom address, low byte
	endtask

	initial begin
		lfsr           = 16'd89;
		rst_n          = 1'b0;
		sysclkf_ce     = 1'b0;
		cpu            = make_bus(24'h0, 1'b1, 1'b1, 1'b1, 1'b1, 8'h00);
		map_ctrl       = 8'h00;
		rom_mask       = '1;
		bsram_mask     = '1;
		rom_q          = 16'h0000;
		bsram_q        = 8'h00;
		msu_enable     = 1'b0;
		track_mounting = 1'b0;
		track_missing  = 1'b0;
		audio_stop     = 1'b0;
		repeat (16) @(posedge mclk);
		#1;
		reset_values();
		rst_n = 1'b1;
		next_edge();
		reset_values();
		lorom_reads();
		hirom_bsram();
		flash_writes();
		audio_regs();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== cart_top.sv ====
`timescale 1ns/100ps

module cart_top (
	input  logic                  mclk,
	input  logic                  rst_n,
	input  logic                  sysclkf_ce,
	input  cart_pkg::cpu_bus_t    cpu,
	output cart_pkg::cpu_data_t   cpu_di,
	input  cart_pkg::map_ctrl_t   map_ctrl,
	input  cart_pkg::rom_addr_t   rom_mask,
	input  cart_pkg::bsram_addr_t bsram_mask,
	input  cart_pkg::rom_data_t   rom_q,
	input  cart_pkg::cpu_data_t   bsram_q,
	output cart_pkg::cart_bus_t   cart,
	output logic                  map_active,
	input  logic                  msu_enable,
	input  logic                  track_mounting,
	input  logic                  track_missing,
	input  logic                  audio_stop,
	output cart_pkg::track_t      track_num,
	output logic                  track_request,
	output cart_pkg::cpu_data_t   volume,
	output logic                  audio_playing,
	output logic                  audio_repeat
);
	import cart_pkg::*;

	cart_bus_t def_req;
	cart_bus_t flash_req;
	cpu_data_t def_dout;
	cpu_data_t flash_dout;
	cpu_data_t msu_dout;
	logic      msu_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mappers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	lohi_rom_map lohi_map (
		.bus        (cpu),
		.rom_q      (rom_q),
		.bsram_q    (bsram_q),
		.map_ctrl   (map_ctrl),
		.rom_mask   (rom_mask),
		.bsram_mask (bsram_mask),
		.req        (def_req),
		.dout       (def_dout)
	);

	flash_rom_map flash_map (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.sysclkf_ce (sysclkf_ce),
		.bus        (cpu),
		.rom_q      (rom_q),
		.map_ctrl   (map_ctrl),
		.rom_mask   (rom_mask),
		.req        (flash_req),
		.dout       (flash_dout),
		.map_active (map_active)
	);

	msu_regs msu (
		.mclk           (mclk),
		.rst_n          (rst_n),
		.sysclkf_ce     (sysclkf_ce),
		.bus            (cpu),
		.msu_enable     (msu_enable),
		.track_mounting (track_mounting),
		.track_missing  (track_missing),
		.audio_stop     (audio_stop),
		.msu_sel        (msu_sel),
		.dout           (msu_dout),
		.track_num      (track_num),
		.track_request  (track_request),
		.volume         (volume),
		.audio_playing  (audio_playing),
		.audio_repeat   (audio_repeat)
	);

	map_mux mux (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.map_active (map_active),
		.def_req    (def_req),
		.flash_req  (flash_req),
		.def_dout   (def_dout),
		.flash_dout (flash_dout),
		.msu_sel    (msu_sel),
		.msu_dout   (msu_dout),
		.cart       (cart),
		.cpu_di     (cpu_di)
	);

endmodule

// ==== map_mux.sv ====
`timescale 1ns/100ps

module map_mux (
	input  logic                mclk,
	input  logic                rst_n,
	input  logic                map_active,
	input  cart_pkg::cart_bus_t def_req,
	input  cart_pkg::cart_bus_t flash_req,
	input  cart_pkg::cpu_data_t def_dout,
	input  cart_pkg::cpu_data_t flash_dout,
	input  logic                msu_sel,
	input  cart_pkg::cpu_data_t msu_dout,
	output cart_pkg::cart_bus_t cart,
	output cart_pkg::cpu_data_t cpu_di
);
	import cart_pkg::*;

	// all strobes released
	localparam cart_bus_t cart_idle = '{
		rom_ce_n:   1'b1,
		rom_oe_n:   1'b1,
		rom_we_n:   1'b1,
		bsram_ce_n: 1'b1,
		bsram_oe_n: 1'b1,
		bsram_we_n: 1'b1,
		default:    '0
	};

	cart_bus_t sel_req;
	cpu_data_t map_dout;

	assign sel_req  = map_active ? flash_req : def_req;
	assign map_dout = map_active ? flash_dout : def_dout;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pin register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			cart <= cart_idle;
		end else begin
			cart <= sel_req;
		end
	end

	assign cpu_di = msu_sel ? msu_dout : map_dout;  // audio regs win

endmodule

// ==== msu_regs.sv ====
`timescale 1ns/100ps
`include "cart_settings.svh"

module msu_regs (
	input  logic                mclk,
	input  logic                rst_n,
	input  logic                sysclkf_ce,
	input  cart_pkg::cpu_bus_t  bus,
	input  logic                msu_enable,
	input  logic                track_mounting,
	input  logic                track_missing,
	input  logic                audio_stop,
	output logic                msu_sel,
	output cart_pkg::cpu_data_t dout,
	output cart_pkg::track_t    track_num,
	output logic                track_request,
	output cart_pkg::cpu_data_t volume,
	output logic                audio_playing,
	output logic                audio_repeat
);
	import cart_pkg::*;

	logic [15:0] reg_off;
	logic [2:0]  reg_idx;
	logic        in_window;
	logic        wr_stb;
	msu_status_t status;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register window, banks 00-3f and 80-bf
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign reg_off   = bus.ca[15:0] - `CART_MSU_BASE;
	assign reg_idx   = reg_off[2:0];
	assign in_window = !bus.ca[22] && bus.ramsel_n && (reg_off[15:3] == 13'd0);
	assign msu_sel   = msu_enable && in_window && (reg_idx != 3'd1);  // 2001 unmapped
	assign wr_stb    = sysclkf_ce && !bus.wr_n && msu_sel;

	assign status = '{track_mounting, track_missing, audio_playing, audio_repeat};

	always_comb begin
		case (reg_idx)
			3'd0:    dout = {1'b0, status.track_mounting, status.repeat_en, status.playing,
				status.track_missing, `CART_MSU_REVISION};
			3'd2:    dout = `CART_MSU_ID0;
			3'd3:    dout = `CART_MSU_ID1;
			3'd4:    dout = `CART_MSU_ID2;
			3'd5:    dout = `CART_MSU_ID3;
			3'd6:    dout = `CART_MSU_ID4;
			3'd7:    dout = `CART_MSU_ID5;
			default: dout = 8'h00;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			track_num     <= '0;
			volume        <= '0;
			audio_playing <= 1'b0;
			audio_repeat  <= 1'b0;
			track_request <= 1'b0;
		end else begin
			track_request <= wr_stb && (reg_idx == 3'd5);  // single pulse per strobe
			if (wr_stb) begin
				case (reg_idx)
					3'd4:    track_num[7:0]  <= bus.dout;
					3'd5:    track_num[15:8] <= bus.dout;
					3'd6:    volume          <= bus.dout;
					3'd7: begin
						audio_playing <= bus.dout[0];
						audio_repeat  <= bus.dout[1];
					end
					default: ;
				endcase
			end
			if (audio_stop) begin
				audio_playing <= 1'b0;   // end of track from the player
			end
		end
	end

endmodule

// ==== flash_rom_map.sv ====
`timescale 1ns/100ps
`include "cart_settings.svh"

module flash_rom_map (
	input  logic                mclk,
	input  logic                rst_n,
	input  logic                sysclkf_ce,
	input  cart_pkg::cpu_bus_t  bus,
	input  cart_pkg::rom_data_t rom_q,
	input  cart_pkg::map_ctrl_t map_ctrl,
	input  cart_pkg::rom_addr_t rom_mask,
	output cart_pkg::cart_bus_t req,
	output cart_pkg::cpu_data_t dout,
	output logic                map_active
);
	import cart_pkg::*;

	logic      flash_wen;
	logic      wen_hit;
	logic      rom_sel;
	rom_addr_t rom_a;

	assign map_active = (map_ctrl[3:0] == `CART_MAP_FLASH);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write enable register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wen_hit = (bus.ca[23:20] == `CART_FLASH_WEN_BANKS) &&
		(bus.ca[15:0] == `CART_FLASH_WEN_ADDR);

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			flash_wen <= 1'b0;
		end else if (sysclkf_ce && !bus.wr_n && wen_hit) begin
			flash_wen <= bus.dout[0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hirom layout, rom writable once enabled
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rom_sel = !bus.romsel_n;
	assign rom_a   = {2'b00, bus.ca[21:0]} & rom_mask;

	always_comb begin
		req            = '0;
		req.rom_addr   = rom_a;
		req.rom_d      = bus.dout;
		req.rom_ce_n   = !rom_sel;
		req.rom_oe_n   = !(rom_sel && !bus.rd_n);
		req.rom_we_n   = !(rom_sel && !bus.wr_n && flash_wen);
		req.bsram_ce_n = 1'b1;   // no save ram on this cart
		req.bsram_oe_n = 1'b1;
		req.bsram_we_n = 1'b1;
	end

	assign dout = rom_a[0] ? rom_q[15:8] : rom_q[7:0];

endmodule

// ==== lohi_rom_map.sv ====
`timescale 1ns/100ps

module lohi_rom_map (
	input  cart_pkg::cpu_bus_t    bus,
	input  cart_pkg::rom_data_t   rom_q,
	input  cart_pkg::cpu_data_t   bsram_q,
	input  cart_pkg::map_ctrl_t   map_ctrl,
	input  cart_pkg::rom_addr_t   rom_mask,
	input  cart_pkg::bsram_addr_t bsram_mask,
	output cart_pkg::cart_bus_t   req,
	output cart_pkg::cpu_data_t   dout
);
	import cart_pkg::*;

	logic        hirom;
	logic        lo_ram_bank;
	logic        rom_sel;
	logic        ram_sel;
	rom_addr_t   rom_a;
	bsram_addr_t ram_a;
	cpu_data_t   rom_byte;

	assign hirom = map_ctrl[0];   // 0 lorom, 1 hirom

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// region decode and address folding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lo_ram_bank = (bus.ca[23:16] >= 8'h70) && (bus.ca[23:16] <= 8'h7D);

	always_comb begin
		if (hirom) begin
			ram_sel = (bus.ca[22:21] == 2'b01) && (bus.ca[15:13] == 3'b011);  // 20-3f/a0-bf:6000-7fff
			rom_a   = {2'b00, bus.ca[21:0]};
			ram_a   = {2'b00, bus.ca[20:16], bus.ca[12:0]};
		end else begin
			ram_sel = lo_ram_bank && !bus.ca[15];
			rom_a   = {2'b00, bus.ca[22:16], bus.ca[14:0]};  // drop a15
			ram_a   = {1'b0, bus.ca[19:16], bus.ca[14:0]};
		end
		rom_sel = !bus.romsel_n && !ram_sel;   // bsram wins in overlap
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pin request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		req            = '0;
		req.rom_addr   = rom_a & rom_mask;
		req.rom_ce_n   = !rom_sel;
		req.rom_oe_n   = !(rom_sel && !bus.rd_n);
		req.rom_we_n   = 1'b1;   // rom is read only here
		req.bsram_addr = ram_a & bsram_mask;
		req.bsram_d    = bus.dout;
		req.bsram_ce_n = !ram_sel;
		req.bsram_oe_n = !(ram_sel && !bus.rd_n);
		req.bsram_we_n = !(ram_sel && !bus.wr_n);
	end

	// byte lane of the 16 bit rom word
	assign rom_byte = req.rom_addr[0] ? rom_q[15:8] : rom_q[7:0];

	assign dout = ram_sel ? bsram_q : rom_byte;

endmodule

// ==== cart_pkg.sv ====
package cart_pkg;

	typedef logic [23:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [23:0] rom_addr_t;
	typedef logic [15:0] rom_data_t;
	typedef logic [19:0] bsram_addr_t;
	typedef logic [7:0]  map_ctrl_t;
	typedef logic [15:0] track_t;

	// one cpu bus cycle
	typedef struct packed {
		cpu_addr_t ca;
		logic      rd_n;
		logic      wr_n;
		logic      romsel_n;
		logic      ramsel_n;
		cpu_data_t dout;      // write data from the cpu
	} cpu_bus_t;

	// pin request of one mapper
	typedef struct packed {
		rom_addr_t   rom_addr;
		cpu_data_t   rom_d;
		logic        rom_ce_n;
		logic        rom_oe_n;
		logic        rom_we_n;
		bsram_addr_t bsram_addr;
		cpu_data_t   bsram_d;
		logic        bsram_ce_n;
		logic        bsram_oe_n;
		logic        bsram_we_n;
	} cart_bus_t;

	typedef struct packed {
		logic track_mounting;
		logic track_missing;
		logic playing;
		logic repeat_en;
	} msu_status_t;

endpackage

// ==== cart_settings.svh ====
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cartridge type, low nibble of map_ctrl
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CART_MAP_LOROM        4'h0
`define CART_MAP_HIROM        4'h1
`define CART_MAP_FLASH        4'h3

// flash write enable register
`define CART_FLASH_WEN_ADDR   16'h5000
`define CART_FLASH_WEN_BANKS  4'h0     // bank bits 23:20, banks 00-0f

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// audio track registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CART_MSU_BASE         16'h2000
`define CART_MSU_ID0          8'h53    // S
`define CART_MSU_ID1          8'h2D    // -
`define CART_MSU_ID2          8'h4D    // M
`define CART_MSU_ID3          8'h53    // S
`define CART_MSU_ID4          8'h55    // U
`define CART_MSU_ID5          8'h31    // 1
`define CART_MSU_REVISION     3'd1

`endif
